//--- source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and address width, bus is word addressed
`define CPU_WIDTH 32

// register file layout
`define CPU_NREGS    16
`define CPU_PC_IDX   15   // r15 is the program counter
`define CPU_LINK_IDX 14   // return address of a call

// width of the alu operation field, instr[19:16]
`define CPU_ALUOP_W 4

`endif

//--- source/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

   // instruction class in instr[27:25], codes 1 and 3 run as no-ops
   typedef enum logic [2:0] {
      OP_ALU  = 3'd0,
      OP_CALL = 3'd2,
      OP_STR  = 3'd4,
      OP_LDR  = 3'd5,
      OP_STI  = 3'd6,   // store, ra + im16
      OP_LDI  = 3'd7    // load, ra + im16
   } opcode_e;

   // condition field in instr[31:28]
   typedef enum logic [3:0] {
      COND_AL, COND_EQ, COND_NE, COND_CS,
      COND_CC, COND_MI, COND_PL, COND_VS,
      COND_VC, COND_HI, COND_LS, COND_GE,
      COND_LT, COND_GT, COND_LE, COND_UN
   } cond_e;

   // alu operation in instr[19:16]
   typedef enum logic [`CPU_ALUOP_W-1:0] {
      ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
      ALU_AND, ALU_OR,  ALU_XOR, ALU_MOV,
      ALU_CMP, ALU_TST, ALU_SHL, ALU_SHR,
      ALU_SAR, ALU_NOT, ALU_RSB, ALU_NOP
   } alu_op_e;

   typedef struct packed {
      logic c;   // carry, no borrow on subtract
      logic v;   // signed overflow
      logic s;   // sign
      logic z;   // zero
   } flags_t;

endpackage

//--- source/cpu_control.sv
`include "cpu_defines.svh"

module cpu_control
(
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic [`CPU_WIDTH-1:0]     instr_i,
   input  cpu_pkg::flags_t           flags_new_i,
   input  logic                      alu_wb_i,
   input  logic                      alu_fl_i,
   output logic                      ph_fetch_o,
   output logic                      ph_exec_o,
   output logic                      ph_mem_o,
   output logic                      ph_wb_o,
   output logic [3:0]                ra_o,
   output logic [3:0]                rb_o,
   output logic [3:0]                rd_o,
   output cpu_pkg::alu_op_e          alu_op_o,
   output logic [15:0]               imm16_o,
   output logic [23:0]               imm24_o,
   output logic                      is_alu_o,
   output logic                      is_call_o,
   output logic                      is_load_o,
   output logic                      is_store_o,
   output logic                      is_imm_o,
   output logic                      cond_ok_o,
   output logic                      link_en_o,
   output logic                      reg_we_o,
   output cpu_pkg::flags_t           flags_o
);

   logic [3:0]              phase_q;   // one-hot, zero while fetch is pending
   logic [`CPU_WIDTH-1:0]   instr_q;
   cpu_pkg::flags_t         flags_q;
   cpu_pkg::opcode_e        opcode;
   cpu_pkg::cond_e          cond;
   logic                    flags_we;

   // fetch -> exec -> mem -> wb, first edge after reset enters fetch
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         phase_q <= 4'b0000;
      else if (phase_q == 4'b0000 || phase_q[3])
         phase_q <= 4'b0001;
      else
         phase_q <= phase_q << 1;
   end

   assign ph_fetch_o = phase_q[0];
   assign ph_exec_o  = phase_q[1];
   assign ph_mem_o   = phase_q[2];
   assign ph_wb_o    = phase_q[3];

   // instruction register
   always_ff @(posedge clk)
   begin
      if (ph_fetch_o)
         instr_q <= instr_i;
   end

   assign cond   = cpu_pkg::cond_e'(instr_q[31:28]);
   assign opcode = cpu_pkg::opcode_e'(instr_q[27:25]);

   assign rd_o     = instr_q[23:20];
   assign ra_o     = instr_q[19:16];
   assign rb_o     = instr_q[11:8];
   assign alu_op_o = cpu_pkg::alu_op_e'(instr_q[19:16]);
   assign imm16_o  = instr_q[15:0];
   assign imm24_o  = instr_q[23:0];

   assign is_alu_o   = (opcode == cpu_pkg::OP_ALU);
   assign is_call_o  = (opcode == cpu_pkg::OP_CALL);
   assign is_load_o  = (opcode == cpu_pkg::OP_LDR) || (opcode == cpu_pkg::OP_LDI);
   assign is_store_o = (opcode == cpu_pkg::OP_STR) || (opcode == cpu_pkg::OP_STI);
   // memory ops pick the offset by opcode bit 26, alu and call by bit 24
   assign is_imm_o   = (is_load_o || is_store_o) ? instr_q[26] : instr_q[24];

   // condition test against the flag register
   always_comb
   begin
      case (cond)
         cpu_pkg::COND_EQ: cond_ok_o = flags_q.z;
         cpu_pkg::COND_NE: cond_ok_o = !flags_q.z;
         cpu_pkg::COND_CS: cond_ok_o = flags_q.c;
         cpu_pkg::COND_CC: cond_ok_o = !flags_q.c;
         cpu_pkg::COND_MI: cond_ok_o = flags_q.s;
         cpu_pkg::COND_PL: cond_ok_o = !flags_q.s;
         cpu_pkg::COND_VS: cond_ok_o = flags_q.v;
         cpu_pkg::COND_VC: cond_ok_o = !flags_q.v;
         cpu_pkg::COND_HI: cond_ok_o = flags_q.c && !flags_q.z;   // unsigned >
         cpu_pkg::COND_LS: cond_ok_o = !flags_q.c || flags_q.z;
         cpu_pkg::COND_GE: cond_ok_o = (flags_q.s == flags_q.v);   // signed >=
         cpu_pkg::COND_LT: cond_ok_o = (flags_q.s != flags_q.v);
         cpu_pkg::COND_GT: cond_ok_o = !flags_q.z && (flags_q.s == flags_q.v);
         cpu_pkg::COND_LE: cond_ok_o = flags_q.z || (flags_q.s != flags_q.v);
         default:          cond_ok_o = 1'b1;   // always and uncond
      endcase
   end

   assign link_en_o = ph_mem_o & cond_ok_o & is_call_o;
   // call writes r15, the core forces the write index
   assign reg_we_o  = ph_wb_o & cond_ok_o & ((is_alu_o & alu_wb_i) | is_call_o | is_load_o);
   assign flags_we  = ph_wb_o & cond_ok_o & is_alu_o & alu_fl_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         flags_q <= '0;
      else if (flags_we)
         flags_q <= flags_new_i;
   end

   assign flags_o = flags_q;

   // once out of reset the scheduler never idles or doubles up
   a_phase_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
      $past(arst_n_i) |-> $onehot(phase_q));

endmodule

//--- source/cpu_regfile.sv
`include "cpu_defines.svh"

module cpu_regfile
(
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic [3:0]                ra_i,
   input  logic [3:0]                rb_i,
   input  logic [3:0]                rd_i,
   input  logic [3:0]                wsel_i,
   input  logic                      ph_exec_i,
   input  logic                      link_en_i,
   input  logic                      reg_we_i,
   input  logic [`CPU_WIDTH-1:0]     wdata_i,
   output logic [`CPU_WIDTH-1:0]     ra_data_o,
   output logic [`CPU_WIDTH-1:0]     rb_data_o,
   output logic [`CPU_WIDTH-1:0]     rd_data_o,
   output logic [`CPU_WIDTH-1:0]     pc_o
);

   logic [`CPU_WIDTH-1:0] regs [0:`CPU_NREGS-1];

   // pc step in exec, link in mem, writeback in wb
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < `CPU_NREGS; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (ph_exec_i)
            regs[`CPU_PC_IDX] <= regs[`CPU_PC_IDX] + 1'b1;
         if (link_en_i)
            regs[`CPU_LINK_IDX] <= regs[`CPU_PC_IDX];   // pc already stepped
         if (reg_we_i)
            regs[wsel_i] <= wdata_i;   // r15 here is a jump
      end
   end

   assign ra_data_o = regs[ra_i];
   assign rb_data_o = regs[rb_i];
   assign rd_data_o = regs[rd_i];
   assign pc_o      = regs[`CPU_PC_IDX];

   // link and writeback come from different phases of the scheduler
   a_no_link_wb: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(link_en_i && reg_we_i));

endmodule

//--- source/cpu_alu.sv
`include "cpu_defines.svh"

module cpu_alu
(
   input  cpu_pkg::alu_op_e          op_i,
   input  logic [`CPU_WIDTH-1:0]     a_i,
   input  logic [`CPU_WIDTH-1:0]     b_i,
   input  cpu_pkg::flags_t           flags_i,
   output logic [`CPU_WIDTH-1:0]     result_o,
   output cpu_pkg::flags_t           flags_o,
   output logic                      wb_o,
   output logic                      fl_o
);

   logic [`CPU_WIDTH-1:0]   x;
   logic [`CPU_WIDTH-1:0]   y;
   logic                    cin;
   logic [`CPU_WIDTH:0]     sum;
   logic                    arith;

   // one adder for all arithmetic, subtract as x + ~y + 1
   always_comb
   begin
      x   = a_i;
      y   = b_i;
      cin = 1'b0;
      case (op_i)
         cpu_pkg::ALU_ADC: cin = flags_i.c;
         cpu_pkg::ALU_SUB, cpu_pkg::ALU_CMP:
         begin
            y   = ~b_i;
            cin = 1'b1;
         end
         cpu_pkg::ALU_SBC:
         begin
            y   = ~b_i;
            cin = flags_i.c;
         end
         cpu_pkg::ALU_RSB:
         begin
            x   = b_i;   // reversed, b - a
            y   = ~a_i;
            cin = 1'b1;
         end
         default: ;
      endcase
   end

   assign sum   = {1'b0, x} + {1'b0, y} + {{`CPU_WIDTH{1'b0}}, cin};
   assign arith = op_i inside {cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADC, cpu_pkg::ALU_SUB,
                               cpu_pkg::ALU_SBC, cpu_pkg::ALU_CMP, cpu_pkg::ALU_RSB};

   always_comb
   begin
      case (op_i)
         cpu_pkg::ALU_AND, cpu_pkg::ALU_TST: result_o = a_i & b_i;
         cpu_pkg::ALU_OR:  result_o = a_i | b_i;
         cpu_pkg::ALU_XOR: result_o = a_i ^ b_i;
         cpu_pkg::ALU_MOV: result_o = b_i;
         cpu_pkg::ALU_SHL: result_o = a_i << b_i[4:0];
         cpu_pkg::ALU_SHR: result_o = a_i >> b_i[4:0];
         cpu_pkg::ALU_SAR: result_o = $signed(a_i) >>> b_i[4:0];
         cpu_pkg::ALU_NOT: result_o = ~b_i;
         cpu_pkg::ALU_NOP: result_o = a_i;
         default:          result_o = sum[`CPU_WIDTH-1:0];   // arithmetic group
      endcase
   end

   // logic ops keep c and v
   always_comb
   begin
      flags_o = flags_i;
      if (fl_o)
      begin
         flags_o.s = result_o[`CPU_WIDTH-1];
         flags_o.z = (result_o == '0);
         if (arith)
         begin
            flags_o.c = sum[`CPU_WIDTH];
            flags_o.v = (x[`CPU_WIDTH-1] == y[`CPU_WIDTH-1]) &&
                        (sum[`CPU_WIDTH-1] != x[`CPU_WIDTH-1]);
         end
      end
   end

   assign wb_o = !(op_i inside {cpu_pkg::ALU_CMP, cpu_pkg::ALU_TST, cpu_pkg::ALU_NOP});
   assign fl_o = !(op_i inside {cpu_pkg::ALU_MOV, cpu_pkg::ALU_NOP});

endmodule

//--- source/cpu_memif.sv
`include "cpu_defines.svh"

module cpu_memif
(
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      ph_fetch_i,
   input  logic                      ph_mem_i,
   input  logic                      is_load_i,
   input  logic                      is_store_i,
   input  logic                      is_imm_i,
   input  logic                      is_call_i,
   input  logic                      cond_ok_i,
   input  logic [`CPU_WIDTH-1:0]     pc_i,
   input  logic [`CPU_WIDTH-1:0]     ra_data_i,
   input  logic [`CPU_WIDTH-1:0]     rb_data_i,
   input  logic [`CPU_WIDTH-1:0]     rd_data_i,
   input  logic [15:0]               imm16_i,
   input  logic [23:0]               imm24_i,
   input  logic [`CPU_WIDTH-1:0]     mem_rdata_i,
   output logic [`CPU_WIDTH-1:0]     mem_addr_o,
   output logic [`CPU_WIDTH-1:0]     mem_wdata_o,
   output logic                      mem_we_o,
   output logic                      mem_fetch_o,
   output logic [`CPU_WIDTH-1:0]     load_data_o,
   output logic [`CPU_WIDTH-1:0]     call_target_o
);

   logic [`CPU_WIDTH-1:0]   imm16_sx;
   logic [`CPU_WIDTH-1:0]   imm20_sx;
   logic [`CPU_WIDTH-1:0]   eff_addr;
   logic                    mem_access;

   assign imm16_sx = {{(`CPU_WIDTH-16){imm16_i[15]}}, imm16_i};
   assign imm20_sx = {{(`CPU_WIDTH-20){imm24_i[19]}}, imm24_i[19:0]};

   assign eff_addr = ra_data_i + (is_imm_i ? imm16_sx : rb_data_i);

   // absolute im24, or rd + im20 when indexed
   assign call_target_o = (is_call_i && is_imm_i) ? rd_data_i + imm20_sx
                                                  : {{(`CPU_WIDTH-24){1'b0}}, imm24_i};

   // pc on the bus except for a live load/store in mem
   assign mem_access  = ph_mem_i & cond_ok_i & (is_load_i | is_store_i);
   assign mem_addr_o  = mem_access ? eff_addr : pc_i;
   assign mem_fetch_o = ph_fetch_i;
   assign mem_we_o    = mem_access & is_store_i;
   assign mem_wdata_o = rd_data_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         load_data_o <= '0;
      else if (mem_access && is_load_i)
         load_data_o <= mem_rdata_i;   // held until writeback
   end

   // a store always sits two cycles after its fetch
   a_we_in_mem: assert property (@(posedge clk) disable iff (!arst_n_i)
      mem_we_o |-> $past(mem_fetch_o, 2));

endmodule

//--- source/cpu_core.sv
`include "cpu_defines.svh"

module cpu_core
(
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic [`CPU_WIDTH-1:0]     mem_rdata_i,
   output logic [`CPU_WIDTH-1:0]     mem_addr_o,
   output logic [`CPU_WIDTH-1:0]     mem_wdata_o,
   output logic                      mem_we_o,
   output logic                      mem_fetch_o
);

   logic                    ph_fetch, ph_exec, ph_mem;
   logic [3:0]              ra, rb, rd, wsel;
   cpu_pkg::alu_op_e        alu_op;
   logic [15:0]             imm16;
   logic [23:0]             imm24;
   logic                    is_alu, is_call, is_load, is_store, is_imm;
   logic                    cond_ok, link_en, reg_we;
   cpu_pkg::flags_t         flags, flags_new;
   logic                    alu_wb, alu_fl;
   logic [`CPU_WIDTH-1:0]   ra_data, rb_data, rd_data, pc;
   logic [`CPU_WIDTH-1:0]   alu_b, alu_result, wdata;
   logic [`CPU_WIDTH-1:0]   load_data, call_target;

   // operand b, writeback index and writeback source
   assign alu_b = is_imm ? {{(`CPU_WIDTH-16){imm16[15]}}, imm16} : rb_data;
   assign wsel  = is_call ? 4'(`CPU_PC_IDX) : rd;
   assign wdata = is_call ? call_target : (is_load ? load_data : alu_result);

   cpu_control u_control (
      .clk (clk), .arst_n_i (arst_n_i), .instr_i (mem_rdata_i),
      .flags_new_i (flags_new), .alu_wb_i (alu_wb), .alu_fl_i (alu_fl),
      .ph_fetch_o (ph_fetch), .ph_exec_o (ph_exec), .ph_mem_o (ph_mem), .ph_wb_o (),
      .ra_o (ra), .rb_o (rb), .rd_o (rd), .alu_op_o (alu_op),
      .imm16_o (imm16), .imm24_o (imm24),
      .is_alu_o (is_alu), .is_call_o (is_call), .is_load_o (is_load),
      .is_store_o (is_store), .is_imm_o (is_imm),
      .cond_ok_o (cond_ok), .link_en_o (link_en), .reg_we_o (reg_we), .flags_o (flags)
   );

   cpu_regfile u_regfile (
      .clk (clk), .arst_n_i (arst_n_i),
      .ra_i (ra), .rb_i (rb), .rd_i (rd), .wsel_i (wsel),
      .ph_exec_i (ph_exec), .link_en_i (link_en), .reg_we_i (reg_we), .wdata_i (wdata),
      .ra_data_o (ra_data), .rb_data_o (rb_data), .rd_data_o (rd_data), .pc_o (pc)
   );

   cpu_alu u_alu (
      .op_i (alu_op), .a_i (rd_data), .b_i (alu_b), .flags_i (flags),
      .result_o (alu_result), .flags_o (flags_new), .wb_o (alu_wb), .fl_o (alu_fl)
   );

   cpu_memif u_memif (
      .clk (clk), .arst_n_i (arst_n_i),
      .ph_fetch_i (ph_fetch), .ph_mem_i (ph_mem),
      .is_load_i (is_load), .is_store_i (is_store), .is_imm_i (is_imm),
      .is_call_i (is_call), .cond_ok_i (cond_ok),
      .pc_i (pc), .ra_data_i (ra_data), .rb_data_i (rb_data), .rd_data_i (rd_data),
      .imm16_i (imm16), .imm24_i (imm24), .mem_rdata_i (mem_rdata_i),
      .mem_addr_o (mem_addr_o), .mem_wdata_o (mem_wdata_o), .mem_we_o (mem_we_o),
      .mem_fetch_o (mem_fetch_o), .load_data_o (load_data), .call_target_o (call_target)
   );

endmodule

//--- bench/cpu_checker.sv
`include "cpu_defines.svh"

module cpu_checker
#(
   parameter int NINSTR = 500
)
(
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic [`CPU_WIDTH-1:0]     addr_i,
   input  logic [`CPU_WIDTH-1:0]     wdata_i,
   input  logic                      we_i,
   input  logic                      fetch_i
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WINDOW = NINSTR * 4 + 2;   // up to the fetch after the last instruction

   logic [`CPU_WIDTH-1:0]   regs [0:`CPU_NREGS-1];
   logic [`CPU_WIDTH-1:0]   mirror [0:255];
   cpu_pkg::flags_t         flags;
   logic [`CPU_WIDTH-1:0]   exp_addr;
   logic [`CPU_WIDTH-1:0]   exp_wdata;
   logic                    exp_access;
   logic                    exp_we;
   logic                    first;
   logic                    done;
   int                      since;   // edges since the last fetch
   int                      edges;   // edges since reset was released
   int                      instr_count;
   int                      test_errors = 0;
   int                      total_errors = 0;
   int                      total_instr = 0;

   task automatic load_word(input int idx, input logic [31:0] w);
      mirror[idx] = w;
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("FAILED at %0d ns: %s expected %h got %h", $time, sig, exp, act);
      test_errors++;
   endtask

   task automatic report_error(input string msg);
      $display("error at %0d ns: %s", $time, msg);
      test_errors++;
   endtask

   task automatic end_test(input string name);
      if (instr_count != NINSTR)
         report_error($sformatf("%0d instructions fetched in the run, expected %0d",
                                instr_count, NINSTR));
      $display("test %s: %0d instructions checked, %0d errors", name, instr_count, test_errors);
      total_errors += test_errors;
      total_instr  += instr_count;
      test_errors   = 0;
   endtask

   function automatic logic cond_holds(input logic [3:0] cc);
      case (cpu_pkg::cond_e'(cc))
         cpu_pkg::COND_EQ: return flags.z;
         cpu_pkg::COND_NE: return !flags.z;
         cpu_pkg::COND_CS: return flags.c;
         cpu_pkg::COND_CC: return !flags.c;
         cpu_pkg::COND_MI: return flags.s;
         cpu_pkg::COND_PL: return !flags.s;
         cpu_pkg::COND_VS: return flags.v;
         cpu_pkg::COND_VC: return !flags.v;
         cpu_pkg::COND_HI: return flags.c && !flags.z;
         cpu_pkg::COND_LS: return !flags.c || flags.z;
         cpu_pkg::COND_GE: return flags.s == flags.v;
         cpu_pkg::COND_LT: return flags.s != flags.v;
         cpu_pkg::COND_GT: return !flags.z && (flags.s == flags.v);
         cpu_pkg::COND_LE: return flags.z || (flags.s != flags.v);
         default: return 1'b1;   // always and uncond
      endcase
   endfunction

   // rd op source with carry meaning no borrow on subtract
   task automatic run_alu(input logic [31:0] w);
      logic [31:0]       a;
      logic [31:0]       b;
      logic [31:0]       x;
      logic [31:0]       y;
      logic [31:0]       r;
      logic [32:0]       wide;
      logic              arith;
      logic              sub;
      logic              cin;
      cpu_pkg::alu_op_e  op;
      a     = regs[w[23:20]];
      b     = w[24] ? {{16{w[15]}}, w[15:0]} : regs[w[11:8]];
      op    = cpu_pkg::alu_op_e'(w[19:16]);
      x     = a;
      y     = b;
      cin   = 1'b0;
      arith = 1'b1;
      sub   = 1'b0;
      wide  = '0;
      case (op)
         cpu_pkg::ALU_ADD: ;
         cpu_pkg::ALU_ADC: cin = flags.c;
         cpu_pkg::ALU_SUB, cpu_pkg::ALU_CMP: sub = 1'b1;
         cpu_pkg::ALU_SBC:
         begin
            sub = 1'b1;
            cin = !flags.c;   // borrow in
         end
         cpu_pkg::ALU_RSB:
         begin
            sub = 1'b1;
            x   = b;
            y   = a;
         end
         default: arith = 1'b0;
      endcase
      case (op)
         cpu_pkg::ALU_AND, cpu_pkg::ALU_TST: r = a & b;
         cpu_pkg::ALU_OR:  r = a | b;
         cpu_pkg::ALU_XOR: r = a ^ b;
         cpu_pkg::ALU_MOV: r = b;
         cpu_pkg::ALU_SHL: r = a << b[4:0];
         cpu_pkg::ALU_SHR: r = a >> b[4:0];
         cpu_pkg::ALU_SAR: r = $signed(a) >>> b[4:0];
         cpu_pkg::ALU_NOT: r = ~b;
         cpu_pkg::ALU_NOP: r = a;
         default:
         begin
            wide = sub ? {1'b0, x} - y - cin : {1'b0, x} + y + cin;
            r    = wide[31:0];
         end
      endcase
      if (!(op inside {cpu_pkg::ALU_MOV, cpu_pkg::ALU_NOP}))
      begin
         flags.s = r[31];
         flags.z = (r == '0);
         if (arith)
         begin
            flags.c = sub ? !wide[32] : wide[32];
            flags.v = (sub ? x[31] != y[31] : x[31] == y[31]) && (r[31] != x[31]);
         end
      end
      if (!(op inside {cpu_pkg::ALU_CMP, cpu_pkg::ALU_TST, cpu_pkg::ALU_NOP}))
         regs[w[23:20]] = r;
   endtask

   // one whole instruction and what its mem phase must show
   task automatic execute(input logic [31:0] w);
      logic [31:0]       ea;
      logic [3:0]        rd;
      logic              ld;
      logic              st;
      cpu_pkg::opcode_e  opc;
      rd  = w[23:20];
      opc = cpu_pkg::opcode_e'(w[27:25]);
      ld  = (opc == cpu_pkg::OP_LDR) || (opc == cpu_pkg::OP_LDI);
      st  = (opc == cpu_pkg::OP_STR) || (opc == cpu_pkg::OP_STI);
      exp_access = 1'b0;
      exp_we     = 1'b0;
      regs[`CPU_PC_IDX] = regs[`CPU_PC_IDX] + 1;   // taken or not
      if (cond_holds(w[31:28]))
      begin
         if (opc == cpu_pkg::OP_ALU)
            run_alu(w);
         else if (opc == cpu_pkg::OP_CALL)
         begin
            regs[`CPU_LINK_IDX] = regs[`CPU_PC_IDX];
            regs[`CPU_PC_IDX]   = w[24] ? regs[rd] + {{12{w[19]}}, w[19:0]}
                                        : {8'h00, w[23:0]};
         end
         else if (ld || st)
         begin
            ea = regs[w[19:16]];
            if (opc == cpu_pkg::OP_LDI || opc == cpu_pkg::OP_STI)
               ea = ea + {{16{w[15]}}, w[15:0]};
            else
               ea = ea + regs[w[11:8]];
            exp_access = 1'b1;
            exp_addr   = ea;
            if (st)
            begin
               exp_we          = 1'b1;
               exp_wdata       = regs[rd];
               mirror[ea[7:0]] = regs[rd];
            end
            else
               regs[rd] = mirror[ea[7:0]];
         end
      end
   endtask

   always @(posedge clk)
   begin
      if (!arst_n_i)
      begin
         if (we_i || fetch_i)
            report_error("store or fetch strobe seen while reset is held");
         for (int i = 0; i < `CPU_NREGS; i++)
            regs[i] = '0;
         flags       = '0;
         since       = 0;
         edges       = 0;
         first       = 1'b1;
         done        = 1'b0;
         exp_access  = 1'b0;
         exp_we      = 1'b0;
         instr_count = 0;
      end
      else if (!done)
      begin
         edges = edges + 1;
         since = since + 1;
         if (we_i !== (since == 2 && exp_we))
            report_mismatch("mem_we_o", (since == 2 && exp_we), we_i);
         if (since == 2 && exp_access && addr_i !== exp_addr)
            report_mismatch("mem_addr_o (mem phase)", exp_addr, addr_i);
         if (since == 2 && exp_we && wdata_i !== exp_wdata)
            report_mismatch("mem_wdata_o", exp_wdata, wdata_i);
         if (fetch_i)
         begin
            if (since != (first ? 2 : 4))
               report_error($sformatf("fetch strobe came after %0d cycles, not %0d",
                                      since, first ? 2 : 4));
            if (addr_i !== regs[`CPU_PC_IDX])
               report_mismatch("mem_addr_o (fetch)", regs[`CPU_PC_IDX], addr_i);
            first = 1'b0;
            since = 0;
            if (edges < WINDOW)
            begin
               execute(mirror[regs[`CPU_PC_IDX][7:0]]);
               instr_count++;
            end
         end
         else if (!first && since > 4)
         begin
            report_error("no fetch strobe for more than 4 cycles");
            since = 0;
         end
         if (edges == WINDOW)
            done = 1'b1;
      end
   end

endmodule

//--- bench/tb_cpu.sv
`include "cpu_defines.svh"

module tb_cpu;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NTESTS = 4;
   localparam int NINSTR = 500;
   localparam int LIMIT  = NTESTS * (NINSTR * 4 + 8) * 11 / 10;   // 10 percent spare

   logic                    clk;
   logic                    arst_n_i;
   logic [`CPU_WIDTH-1:0]   mem_rdata;
   logic [`CPU_WIDTH-1:0]   mem_addr;
   logic [`CPU_WIDTH-1:0]   mem_wdata;
   logic                    mem_we;
   logic                    mem_fetch;
   logic [`CPU_WIDTH-1:0]   mem [0:255];
   logic [31:0]             lfsr;
   int                      cycles = 0;

   cpu_core u_dut (
      .clk (clk), .arst_n_i (arst_n_i), .mem_rdata_i (mem_rdata),
      .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata), .mem_we_o (mem_we),
      .mem_fetch_o (mem_fetch)
   );

   cpu_checker #(.NINSTR (NINSTR)) u_check (
      .clk (clk), .arst_n_i (arst_n_i), .addr_i (mem_addr), .wdata_i (mem_wdata),
      .we_i (mem_we), .fetch_i (mem_fetch)
   );

   always #4 clk = ~clk;

   // word memory on the low 8 address bits
   always @(posedge clk)
   begin
      if (mem_we)
         mem[mem_addr[7:0]] <= mem_wdata;
      #1 mem_rdata = mem[mem_addr[7:0]];
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > LIMIT)
      begin
         $display("timeout after %0d cycles, the DUT did not finish its instructions", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // galois lfsr stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      end
      return v;
   endfunction

   // random word with a per-test opcode and condition mix
   function automatic logic [31:0] gen_word(input int t);
      logic [31:0] w;
      logic [2:0]  r;
      w = rand_bits(32);
      if (rand_bits(3) == 3'd0)
         return w;   // plain data word
      r = 3'(rand_bits(3));
      case (t)
         0: w[27:25] = (r == 3'd6) ? cpu_pkg::OP_STR
                                   : ((r == 3'd7) ? cpu_pkg::OP_STI : cpu_pkg::OP_ALU);
         1: w[27:25] = (r < 3'd2) ? 3'd0 : {1'b1, r[1:0]};   // loads and stores
         2:
         begin
            if (r < 3'd2)
               w[27:25] = cpu_pkg::OP_ALU;
            else if (r < 3'd6)
               w[27:25] = cpu_pkg::OP_CALL;
            else if (r == 3'd6)
               w[27:25] = cpu_pkg::OP_LDI;
            else
               w[27:25] = 3'd3;   // reserved code runs as a no-op
            if (w[27:25] == cpu_pkg::OP_ALU && rand_bits(1) == 1'b1)
               w[23:20] = 4'(`CPU_PC_IDX);   // jump through r15
         end
         default: w[27:25] = r;
      endcase
      if (t < 2 && rand_bits(2) != 2'd0)
         w[31:28] = cpu_pkg::COND_AL;
      return w;
   endfunction

   function automatic string test_name(input int t);
      case (t)
         0: return "alu";
         1: return "memory";
         2: return "branch";
         default: return "mixed";
      endcase
   endfunction

   task automatic run_test(input int t);
      logic [31:0] w;
      @(posedge clk);
      #1 arst_n_i = 1'b0;
      for (int i = 0; i < 256; i++)
      begin
         w      = gen_word(t);
         mem[i] = w;
         u_check.load_word(i, w);
      end
      repeat (8) @(posedge clk);
      #1 arst_n_i = 1'b1;
      while (!u_check.done)
      begin
         @(posedge clk);
         #1;
      end
      u_check.end_test(test_name(t));
   endtask

   initial
   begin
      clk       = 1'b0;
      arst_n_i  = 1'b1;
      mem_rdata = '0;
      lfsr      = 32'd71617;
      #1 arst_n_i = 1'b0;
      for (int t = 0; t < NTESTS; t++)
         run_test(t);
      $display("%0d tests, %0d instructions, %0d errors",
               NTESTS, u_check.total_instr, u_check.total_errors);
      if (u_check.total_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- src.f
+incdir+source
source/cpu_pkg.sv
source/cpu_control.sv
source/cpu_regfile.sv
source/cpu_alu.sv
source/cpu_memif.sv
source/cpu_core.sv
bench/cpu_checker.sv
bench/tb_cpu.sv
